/* Bender.yml */
package:
  name: wb_subsystem

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/cp0_regs.sv
      - rtl/wb_stage.sv
      - rtl/reg_file.sv
      - rtl/wb_subsystem.sv
  - target: test
    files:
      - testbench/tb_wb_subsystem.sv

/* all.f */
rtl/cpu_pkg.sv
rtl/cp0_regs.sv
rtl/wb_stage.sv
rtl/reg_file.sv
rtl/wb_subsystem.sv
testbench/tb_wb_subsystem.sv

/* rtl/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  addr,
    input  logic        wen,
    input  logic [31:0] wdata,
    input  logic        exc,
    input  logic        eret,
    input  logic [31:0] pc,
    input  logic        bd,
    output logic [31:0] rdata,
    output logic [31:0] epc
);

    logic        status_exl;
    logic        status_ie;
    logic        cause_bd;
    logic [4:0]  cause_exccode;
    logic [31:0] epc_q;
    logic [31:0] count;
    logic        tick;

    logic wr_status;
    logic wr_epc;
    logic wr_count;

    assign wr_status = wen && (addr == CP0_STATUS);
    assign wr_epc    = wen && (addr == CP0_EPC);
    assign wr_count  = wen && (addr == CP0_COUNT);

    // status.EXL, set on exception entry and cleared by eret
    always_ff @(posedge clk) begin
        if (reset) begin
            status_exl <= 1'b0;
        end else if (exc) begin
            status_exl <= 1'b1;
        end else if (eret) begin
            status_exl <= 1'b0;
        end
    end

    // status.IE, software only
    always_ff @(posedge clk) begin
        if (reset) begin
            status_ie <= 1'b0;
        end else if (wr_status) begin
            status_ie <= wdata[0];
        end
    end

    // cause.BD only recorded on a fresh entry
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd      <= 1'b0;
            cause_exccode <= 5'd0;
        end else if (exc) begin
            cause_exccode <= EXC_SYSCALL;
            if (!status_exl) begin
                cause_bd <= bd;
            end
        end
    end

    // exception entry wins over mtc0
    always_ff @(posedge clk) begin
        if (reset) begin
            epc_q <= 32'd0;
        end else if (exc && !status_exl) begin
            epc_q <= bd ? pc - 32'd4 : pc;
        end else if (wr_epc) begin
            epc_q <= wdata;
        end
    end

    // count runs at half the core clock
    always_ff @(posedge clk) begin
        if (reset) begin
            tick  <= 1'b0;
            count <= 32'd0;
        end else begin
            tick <= ~tick;
            if (wr_count) begin
                count <= wdata;
            end else if (tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_comb begin
        case (addr)
            CP0_COUNT:  rdata = count;
            CP0_STATUS: rdata = {30'd0, status_exl, status_ie};
            CP0_CAUSE:  rdata = {cause_bd, 24'd0, cause_exccode, 2'b00};
            CP0_EPC:    rdata = epc_q;
            default:    rdata = 32'd0;
        endcase
    end

    assign epc = epc_q;

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    // one retired instruction from the memory stage, msb first
    typedef struct packed {
        logic        bd;            // in a branch delay slot
        logic        exc_sys;       // syscall
        logic        eret;
        logic        cp0_wen;       // mtc0
        logic        res_from_cp0;  // mfc0
        logic [7:0]  cp0_addr;      // register number and select
        logic [3:0]  gr_we;         // byte enables for the GPR write
        logic [4:0]  dest;
        logic [31:0] result;        // alu or load result
        logic [31:0] pc;
    } ms_to_ws_t;

    // one register file write
    typedef struct packed {
        logic [3:0]  we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_write_t;

    // writeback view for decode stall and forwarding
    typedef struct packed {
        logic        valid;
        logic [3:0]  we;
        logic [4:0]  dest;
        logic [31:0] result;
    } ws_hazard_t;

    // pipeline redirect on syscall or eret
    typedef struct packed {
        logic        exc;
        logic        eret;
        logic [31:0] target;
    } redirect_t;

    // cp0 register map
    localparam logic [7:0] CP0_COUNT  = 8'd9;
    localparam logic [7:0] CP0_STATUS = 8'd12;
    localparam logic [7:0] CP0_CAUSE  = 8'd13;
    localparam logic [7:0] CP0_EPC    = 8'd14;

    // cause.ExcCode for syscall
    localparam logic [4:0] EXC_SYSCALL = 5'd8;

    // general exception entry, BEV set
    localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380;

endpackage

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  rf_write_t   wr,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    // r0 has no storage
    logic [31:0] regs [31:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr.waddr != 5'd0) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.we[b]) begin
                    regs[wr.waddr][b*8 +: 8] <= wr.wdata[b*8 +: 8];
                end
            end
        end
    end

    // no write bypass, decode forwards from the hazard view
    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = 32'd0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == 5'd0) begin
            rdata2 = 32'd0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* rtl/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        ms_valid,
    input  ms_to_ws_t   ms_bus,
    input  logic [31:0] cp0_rdata,
    input  logic [31:0] cp0_epc,
    output rf_write_t   rf_wr,
    output logic [7:0]  cp0_addr,
    output logic        cp0_wen,
    output logic [31:0] cp0_wdata,
    output logic        cp0_exc,
    output logic        cp0_eret,
    output logic [31:0] cp0_pc,
    output logic        cp0_bd,
    output ws_hazard_t  hazard,
    output redirect_t   redirect,
    output logic        send_flush,
    output logic [31:0] trace_pc,
    output logic [3:0]  trace_rf_wen,
    output logic [4:0]  trace_rf_wnum,
    output logic [31:0] trace_rf_wdata
);

    logic        ws_valid;
    ms_to_ws_t   ws_bus;
    logic [31:0] final_result;
    logic [3:0]  rf_we;
    logic        sys_fire;
    logic        eret_fire;

    // stage never stalls, a flush drops whatever arrives
    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (flush) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid && !flush) begin
            ws_bus <= ms_bus;
        end
    end

    assign sys_fire  = ws_valid && ws_bus.exc_sys;
    assign eret_fire = ws_valid && ws_bus.eret;

    // mfc0 takes the cp0 read data
    assign final_result = ws_bus.res_from_cp0 ? cp0_rdata : ws_bus.result;

    // syscall and eret never touch a GPR
    assign rf_we = (ws_valid && !ws_bus.exc_sys && !ws_bus.eret) ? ws_bus.gr_we : 4'd0;

    assign rf_wr.we    = rf_we;
    assign rf_wr.waddr = ws_bus.dest;
    assign rf_wr.wdata = final_result;

    assign cp0_addr  = ws_bus.cp0_addr;
    assign cp0_wen   = ws_valid && ws_bus.cp0_wen;
    assign cp0_wdata = ws_bus.result;
    assign cp0_exc   = sys_fire;
    assign cp0_eret  = eret_fire;
    assign cp0_pc    = ws_bus.pc;
    assign cp0_bd    = ws_bus.bd;

    assign hazard.valid  = ws_valid;
    assign hazard.we     = rf_we;
    assign hazard.dest   = ws_bus.dest;
    assign hazard.result = final_result;

    // eret returns through the live epc
    assign redirect.exc    = sys_fire;
    assign redirect.eret   = eret_fire;
    assign redirect.target = sys_fire ? EXC_VECTOR : cp0_epc;

    assign send_flush = sys_fire || eret_fire;

    assign trace_pc       = ws_bus.pc;
    assign trace_rf_wen   = rf_we;
    assign trace_rf_wnum  = ws_bus.dest;
    assign trace_rf_wdata = final_result;

endmodule

/* rtl/wb_subsystem.sv */
`timescale 1ns/1ps

module wb_subsystem import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        ms_valid,
    input  ms_to_ws_t   ms_bus,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    output ws_hazard_t  hazard,
    output redirect_t   redirect,
    output logic        send_flush,
    output logic [31:0] trace_pc,
    output logic [3:0]  trace_rf_wen,
    output logic [4:0]  trace_rf_wnum,
    output logic [31:0] trace_rf_wdata
);

    rf_write_t   rf_wr;
    logic [7:0]  cp0_addr;
    logic        cp0_wen;
    logic [31:0] cp0_wdata;
    logic        cp0_exc;
    logic        cp0_eret;
    logic [31:0] cp0_pc;
    logic        cp0_bd;
    logic [31:0] cp0_rdata;
    logic [31:0] cp0_epc;

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ms_valid       (ms_valid),
        .ms_bus         (ms_bus),
        .cp0_rdata      (cp0_rdata),
        .cp0_epc        (cp0_epc),
        .rf_wr          (rf_wr),
        .cp0_addr       (cp0_addr),
        .cp0_wen        (cp0_wen),
        .cp0_wdata      (cp0_wdata),
        .cp0_exc        (cp0_exc),
        .cp0_eret       (cp0_eret),
        .cp0_pc         (cp0_pc),
        .cp0_bd         (cp0_bd),
        .hazard         (hazard),
        .redirect       (redirect),
        .send_flush     (send_flush),
        .trace_pc       (trace_pc),
        .trace_rf_wen   (trace_rf_wen),
        .trace_rf_wnum  (trace_rf_wnum),
        .trace_rf_wdata (trace_rf_wdata)
    );

    cp0_regs u_cp0_regs (
        .clk   (clk),
        .reset (reset),
        .addr  (cp0_addr),
        .wen   (cp0_wen),
        .wdata (cp0_wdata),
        .exc   (cp0_exc),
        .eret  (cp0_eret),
        .pc    (cp0_pc),
        .bd    (cp0_bd),
        .rdata (cp0_rdata),
        .epc   (cp0_epc)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .wr     (rf_wr),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

/* testbench/tb_wb_subsystem.sv */
`timescale 1ns/1ps

module tb_wb_subsystem import cpu_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int WAIT_LIMIT = 20;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        ms_valid;
    ms_to_ws_t   ms_bus;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    ws_hazard_t  hazard;
    redirect_t   redirect;
    logic        send_flush;
    logic [31:0] trace_pc;
    logic [3:0]  trace_rf_wen;
    logic [4:0]  trace_rf_wnum;
    logic [31:0] trace_rf_wdata;

    integer seed = 32'hd600e893;
    int     errors = 0;

    // reference model state
    logic        exp_valid;
    ms_to_ws_t   exp_bus = '0;
    logic [31:0] m_regs [32];
    logic [31:0] m_epc;
    logic        m_exl;
    logic        m_ie;
    logic        m_bd;
    logic [4:0]  m_code;
    logic [31:0] m_cp0;
    logic        exp_exc;
    logic        exp_eret;
    logic [3:0]  exp_wen;
    logic [31:0] exp_result;
    logic [31:0] exp_target;
    logic [31:0] exp_rd1;
    logic [31:0] exp_rd2;

    logic [31:0] pc1;
    logic [31:0] pc3;
    logic [31:0] val;

    wb_subsystem UUT (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ms_valid       (ms_valid),
        .ms_bus         (ms_bus),
        .raddr1         (raddr1),
        .raddr2         (raddr2),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .hazard         (hazard),
        .redirect       (redirect),
        .send_flush     (send_flush),
        .trace_pc       (trace_pc),
        .trace_rf_wen   (trace_rf_wen),
        .trace_rf_wnum  (trace_rf_wnum),
        .trace_rf_wdata (trace_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // what the writeback cycle should show, from the model
    always_comb begin
        case (exp_bus.cp0_addr)
            CP0_STATUS: m_cp0 = {30'd0, m_exl, m_ie};
            CP0_CAUSE:  m_cp0 = {m_bd, 24'd0, m_code, 2'b00};
            CP0_EPC:    m_cp0 = m_epc;
            default:    m_cp0 = 32'd0;
        endcase
        exp_exc    = exp_valid && exp_bus.exc_sys;
        exp_eret   = exp_valid && exp_bus.eret;
        exp_wen    = (exp_valid && !exp_exc && !exp_eret) ? exp_bus.gr_we : 4'h0;
        exp_result = exp_bus.res_from_cp0 ? m_cp0 : exp_bus.result;
        exp_target = exp_exc ? EXC_VECTOR : m_epc;
        exp_rd1    = (raddr1 == 5'd0) ? 32'd0 : m_regs[raddr1];
        exp_rd2    = (raddr2 == 5'd0) ? 32'd0 : m_regs[raddr2];
    end

    // model commit at the end of the writeback cycle
    always @(posedge clk) begin
        if (reset) begin
            exp_valid <= 1'b0;
            m_epc     <= 32'd0;
            m_exl     <= 1'b0;
            m_ie      <= 1'b0;
            m_bd      <= 1'b0;
            m_code    <= 5'd0;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] <= 32'd0;
            end
        end else begin
            exp_valid <= ms_valid && !flush;
            if (ms_valid && !flush) begin
                exp_bus <= ms_bus;
            end
            if (exp_bus.dest != 5'd0) begin
                for (int b = 0; b < 4; b++) begin
                    if (exp_wen[b]) begin
                        m_regs[exp_bus.dest][b*8 +: 8] <= exp_result[b*8 +: 8];
                    end
                end
            end
            if (exp_exc) begin
                m_code <= EXC_SYSCALL;
                if (!m_exl) begin
                    m_exl <= 1'b1;
                    m_bd  <= exp_bus.bd;
                    m_epc <= exp_bus.bd ? exp_bus.pc - 32'd4 : exp_bus.pc;
                end
            end else begin
                if (exp_eret) begin
                    m_exl <= 1'b0;
                end
                if (exp_valid && exp_bus.cp0_wen && exp_bus.cp0_addr == CP0_STATUS) begin
                    m_ie <= exp_bus.result[0];
                end
                if (exp_valid && exp_bus.cp0_wen && exp_bus.cp0_addr == CP0_EPC) begin
                    m_epc <= exp_bus.result;
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        errors++;
        $display("** Error: %s expected %h got %h at %0t", name, want, got, $time);
    endtask

    assert property (@(posedge clk) disable iff (reset) hazard.valid == exp_valid)
        else report_mismatch("hazard.valid", $sampled(exp_valid), $sampled(hazard.valid));
    assert property (@(posedge clk) disable iff (reset) exp_valid |-> hazard.we == exp_wen)
        else report_mismatch("hazard.we", $sampled(exp_wen), $sampled(hazard.we));
    assert property (@(posedge clk) disable iff (reset)
                     exp_valid |-> hazard.dest == exp_bus.dest)
        else report_mismatch("hazard.dest", $sampled(exp_bus.dest), $sampled(hazard.dest));
    assert property (@(posedge clk) disable iff (reset)
                     exp_valid |-> hazard.result == exp_result)
        else report_mismatch("hazard.result", $sampled(exp_result), $sampled(hazard.result));
    assert property (@(posedge clk) disable iff (reset) trace_rf_wen == exp_wen)
        else report_mismatch("trace_rf_wen", $sampled(exp_wen), $sampled(trace_rf_wen));
    assert property (@(posedge clk) disable iff (reset)
                     exp_wen != 4'h0 |-> trace_rf_wnum == exp_bus.dest)
        else report_mismatch("trace_rf_wnum", $sampled(exp_bus.dest), $sampled(trace_rf_wnum));
    assert property (@(posedge clk) disable iff (reset)
                     exp_wen != 4'h0 |-> trace_rf_wdata == exp_result)
        else report_mismatch("trace_rf_wdata", $sampled(exp_result), $sampled(trace_rf_wdata));
    assert property (@(posedge clk) disable iff (reset) exp_valid |-> trace_pc == exp_bus.pc)
        else report_mismatch("trace_pc", $sampled(exp_bus.pc), $sampled(trace_pc));
    assert property (@(posedge clk) disable iff (reset) redirect.exc == exp_exc)
        else report_mismatch("redirect.exc", $sampled(exp_exc), $sampled(redirect.exc));
    assert property (@(posedge clk) disable iff (reset) redirect.eret == exp_eret)
        else report_mismatch("redirect.eret", $sampled(exp_eret), $sampled(redirect.eret));
    assert property (@(posedge clk) disable iff (reset) send_flush == (exp_exc || exp_eret))
        else report_mismatch("send_flush", $sampled(exp_exc || exp_eret), $sampled(send_flush));
    assert property (@(posedge clk) disable iff (reset)
                     (exp_exc || exp_eret) |-> redirect.target == exp_target)
        else report_mismatch("redirect.target", $sampled(exp_target), $sampled(redirect.target));
    assert property (@(posedge clk) disable iff (reset) rdata1 == exp_rd1)
        else report_mismatch("rdata1", $sampled(exp_rd1), $sampled(rdata1));
    assert property (@(posedge clk) disable iff (reset) rdata2 == exp_rd2)
        else report_mismatch("rdata2", $sampled(exp_rd2), $sampled(rdata2));

    function automatic ms_to_ws_t alu_beat();
        ms_to_ws_t b;
        b        = '0;
        b.gr_we  = $random(seed);
        b.dest   = $random(seed);
        b.result = $random(seed);
        b.pc     = $random(seed);
        b.pc[1:0] = 2'b00;
        return b;
    endfunction

    // mtc0 when wen is set, otherwise mfc0 into dest
    function automatic ms_to_ws_t cp0_beat(input logic [7:0] addr, input logic wen,
                                           input logic [31:0] data, input logic [4:0] dest);
        ms_to_ws_t b;
        b              = '0;
        b.cp0_addr     = addr;
        b.cp0_wen      = wen;
        b.res_from_cp0 = !wen;
        b.gr_we        = wen ? 4'h0 : 4'hf;
        b.dest         = dest;
        b.result       = data;
        return b;
    endfunction

    // syscall or eret, with a live gr_we that must be ignored
    function automatic ms_to_ws_t trap_beat(input logic sys, input logic bd,
                                            input logic [31:0] pc);
        ms_to_ws_t b;
        b         = '0;
        b.exc_sys = sys;
        b.eret    = !sys;
        b.bd      = bd;
        b.pc      = pc;
        b.gr_we   = 4'hf;
        b.dest    = 5'd7;
        b.result  = $random(seed);
        return b;
    endfunction

    // port 1 follows the register written at this edge
    task automatic drive_beat(input ms_to_ws_t b, input logic fl);
        @(posedge clk);
        ms_valid <= 1'b1;
        ms_bus   <= b;
        flush    <= fl;
        raddr1   <= exp_bus.dest;
        raddr2   <= $random(seed);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        ms_valid <= 1'b0;
        flush    <= 1'b0;
    endtask

    task automatic wait_rf_write(input logic [31:0] want);
        int n;
        n = 0;
        @(negedge clk);
        while (trace_rf_wen == 4'h0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n == WAIT_LIMIT) begin
            errors++;
            $display("timeout: no register write seen after an mfc0");
        end else begin
            assert (trace_rf_wdata == want)
                else report_mismatch("trace_rf_wdata", want, trace_rf_wdata);
        end
    endtask

    task automatic wait_redirect(input logic is_exc, input logic [31:0] target);
        int n;
        n = 0;
        @(negedge clk);
        while (!send_flush && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n == WAIT_LIMIT) begin
            errors++;
            $display("timeout: no redirect seen after a syscall or eret");
        end else begin
            assert (redirect.exc == is_exc)
                else report_mismatch("redirect.exc", is_exc, redirect.exc);
            assert (redirect.target == target)
                else report_mismatch("redirect.target", target, redirect.target);
        end
    endtask

    task automatic read_cp0(input logic [7:0] addr, input logic [31:0] want);
        drive_beat(cp0_beat(addr, 1'b0, $random(seed), 5'd9), 1'b0);
        drive_idle();
        wait_rf_write(want);
    endtask

    initial begin
        #(CLK_PERIOD * 4000);
        $display("run did not finish within its time limit");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        flush    = 1'b0;
        ms_valid = 1'b0;
        ms_bus   = '0;
        raddr1   = 5'd0;
        raddr2   = 5'd0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // random alu traffic with gaps
        for (int i = 0; i < 80; i++) begin
            drive_beat(alu_beat(), 1'b0);
            if (($random(seed) & 3) == 0) begin
                drive_idle();
            end
        end
        drive_idle();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            raddr1 <= i;
            raddr2 <= 31 - i;
        end

        // mtc0 then mfc0 of epc, and an unmapped address
        val = $random(seed);
        drive_beat(cp0_beat(CP0_EPC, 1'b1, val, 5'd0), 1'b0);
        drive_idle();
        read_cp0(CP0_EPC, val);
        read_cp0(8'd3, 32'd0);

        // syscall outside a delay slot, then a nested one
        pc1 = {$random(seed)} & 32'hffff_fffc;
        drive_beat(trap_beat(1'b1, 1'b0, pc1), 1'b0);
        drive_idle();
        wait_redirect(1'b1, EXC_VECTOR);
        read_cp0(CP0_EPC, pc1);
        read_cp0(CP0_CAUSE, {1'b0, 24'd0, EXC_SYSCALL, 2'b00});
        read_cp0(CP0_STATUS, 32'h2);
        drive_beat(trap_beat(1'b1, 1'b1, pc1 + 32'h40), 1'b0);
        drive_idle();
        wait_redirect(1'b1, EXC_VECTOR);
        read_cp0(CP0_EPC, pc1);
        drive_beat(trap_beat(1'b0, 1'b0, pc1 + 32'h80), 1'b0);
        drive_idle();
        wait_redirect(1'b0, pc1);
        read_cp0(CP0_STATUS, 32'h0);

        // syscall in a delay slot
        pc3 = {$random(seed)} & 32'hffff_fffc;
        drive_beat(trap_beat(1'b1, 1'b1, pc3), 1'b0);
        drive_idle();
        wait_redirect(1'b1, EXC_VECTOR);
        read_cp0(CP0_EPC, pc3 - 32'd4);
        read_cp0(CP0_CAUSE, {1'b1, 24'd0, EXC_SYSCALL, 2'b00});
        drive_beat(trap_beat(1'b0, 1'b0, pc3 + 32'h10), 1'b0);
        drive_idle();
        wait_redirect(1'b0, pc3 - 32'd4);

        // flush on an arriving beat, and on a valid stage
        drive_beat(alu_beat(), 1'b1);
        drive_beat(alu_beat(), 1'b0);
        drive_beat(alu_beat(), 1'b1);
        for (int i = 0; i < 10; i++) begin
            drive_beat(alu_beat(), 1'b0);
        end
        drive_idle();
        repeat (3) @(posedge clk);

        $display("checks done, error count: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
